// ==== Bender.yml ====
package:
  name: err_log

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/err_log_pkg.sv
      - src/err_event_detect.sv
      - src/err_status_log.sv
      - src/csr_log_writer.sv
      - src/err_log_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - dv/err_log_asserts.sv
      - dv/err_log_tb.sv

// ==== dv/err_log_asserts.sv ====
module err_log_asserts (
  input logic                 i_clk,
  input logic                 i_rst,
  input logic                 i_csr_req,
  input logic                 i_csr_ack,
  input err_log_pkg::csr_wr_t i_csr
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_cnt = 0;

  // Req may only fall once ack has been sampled
  req_held_a: assert property (@(posedge i_clk) disable iff (!i_rst)
    i_csr_req && !i_csr_ack |=> i_csr_req)
    else begin
      $error("CSR request dropped before ack");
      fail_cnt++;
    end

  // Payload frozen for the whole request phase
  csr_stable_a: assert property (@(posedge i_clk) disable iff (!i_rst)
    i_csr_req |=> !i_csr_req || $stable(i_csr))
    else begin
      $error("CSR payload changed while request was high");
      fail_cnt++;
    end

  // No new request until ack is seen low
  no_rise_on_ack_a: assert property (@(posedge i_clk) disable iff (!i_rst)
    !i_csr_req && i_csr_ack |=> !i_csr_req)
    else begin
      $error("CSR request raised while ack was still high");
      fail_cnt++;
    end

  reset_quiet_a: assert property (@(posedge i_clk) !i_rst |-> !i_csr_req)
    else begin
      $error("CSR request high during reset");
      fail_cnt++;
    end

endmodule

// ==== dv/err_log_tb.sv ====
`include "err_log_consts.svh"

module err_log_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int REQ_TIMEOUT = 50;
  localparam int ACK_TIMEOUT = 20;

  logic                       clk = 1'b0;
  logic                       rst;
  err_log_pkg::phy_err_in_t   phy;
  err_log_pkg::adapter_in_t   adp;
  err_log_pkg::sb_err_in_t    sb;
  logic                       tx_overflow;
  logic                       rx_overflow;
  logic                       csr_ack;
  err_log_pkg::fdi_err_t      fdi;
  logic                       csr_req;
  err_log_pkg::csr_wr_t       csr;

  integer seed = 46548;
  int     mismatches = 0;
  int     other_errs = 0;
  int     assert_errs;

  always #5 clk = ~clk;

  err_log_top i_err_log_top (
    .i_clk        (clk),
    .i_rst        (rst),
    .i_phy        (phy),
    .i_adp        (adp),
    .i_sb         (sb),
    .i_tx_overflow(tx_overflow),
    .i_rx_overflow(rx_overflow),
    .i_csr_ack    (csr_ack),
    .o_fdi        (fdi),
    .o_csr_req    (csr_req),
    .o_csr        (csr)
  );

  bind csr_log_writer err_log_asserts u_asserts (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_csr_req(o_csr_req),
    .i_csr_ack(i_csr_ack),
    .i_csr    (o_csr)
  );

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
      mismatches++;
    end
  endtask

  // Expected FDI outputs from the forwarding rule
  function automatic err_log_pkg::fdi_err_t fdi_expected(
    input err_log_pkg::phy_err_in_t p, input err_log_pkg::adapter_in_t a);
    err_log_pkg::fdi_err_t f;
    f.error         = p.error;
    f.cerror        = p.cerror;
    f.nferror       = p.nferror;
    f.trainerror    = p.trainerror | a.invalid_param_exchange;
    f.phyinrecenter = p.phyinrecenter | a.phyinrecenter;
    return f;
  endfunction

  task automatic wait_for_req(output bit seen);
    int cycles;
    cycles = 0;
    while (!csr_req && cycles < REQ_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    seen = csr_req;
    assert (seen) else begin
      $display("ERROR: no CSR request within %0d cycles", cycles);
      other_errs++;
    end
  endtask

  // Responder for one transfer; ack comes after a random delay plus extra_hold
  task automatic expect_write(input logic [7:0] exp_addr, input logic [31:0] exp_data,
                              input int extra_hold);
    bit                   seen;
    int                   hold;
    int                   ack_hold;
    int                   cycles;
    err_log_pkg::csr_wr_t held;
    wait_for_req(seen);
    if (!seen) begin
      return;
    end
    held = csr;
    check_value("o_csr.addr", 64'(held.addr), 64'(exp_addr));
    check_value("o_csr.data", 64'(held.data), 64'(exp_data));
    hold = ($unsigned($random(seed)) % 4) + extra_hold;
    repeat (hold) begin
      @(negedge clk);
      check_value("o_csr_req", 64'(csr_req), 64'h1);
      check_value("o_csr", 64'(csr), 64'(held));
    end
    csr_ack = 1'b1;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (csr_req && cycles < ACK_TIMEOUT);
    assert (!csr_req) else begin
      $display("ERROR: CSR request still high %0d cycles after ack", cycles);
      other_errs++;
    end
    // Ack stays up a while after req falls, req must not come back meanwhile
    ack_hold = ($unsigned($random(seed)) % 3) + 1;
    repeat (ack_hold) begin
      @(negedge clk);
      check_value("o_csr_req", 64'(csr_req), 64'h0);
    end
    csr_ack = 1'b0;
  endtask

  task automatic expect_no_write(input int cycles);
    bit quiet;
    quiet = 1'b1;
    for (int i = 0; i < cycles && quiet; i++) begin
      @(negedge clk);
      quiet = !csr_req;
    end
    assert (quiet) else begin
      $display("ERROR: unexpected CSR request to address 0x%0h", csr.addr);
      other_errs++;
    end
  endtask

  task automatic test_forwarding();
    check_value("o_csr_req", 64'(csr_req), 64'h0);
    for (int i = 0; i < 32; i++) begin
      phy = err_log_pkg::phy_err_in_t'(i[4:0]);
      adp = '0;
      adp.phyinrecenter = i[0] ^ i[3];
      @(negedge clk);
      check_value("o_fdi", 64'(fdi), 64'(fdi_expected(phy, adp)));
    end
    phy = '0;
    adp = '0;
    adp.invalid_param_exchange = 1'b1;
    @(negedge clk);
    check_value("o_fdi", 64'(fdi), 64'(fdi_expected(phy, adp)));
    adp = '0;
    // That pulse is also logged as uncorrectable
    expect_write(`ERR_LOG_REG_UNCORR, 32'h20, 0);
    expect_no_write(10);
  endtask

  task automatic test_single_events();
    sb.src_error = 1'b1;
    @(negedge clk);
    sb.src_error = 1'b0;
    expect_write(`ERR_LOG_REG_INTERNAL, 32'h01, 0);
    expect_write(`ERR_LOG_REG_UNCORR, 32'h04, 0);
    adp.state_transition_timeout = 1'b1;
    @(negedge clk);
    adp.state_transition_timeout = 1'b0;
    expect_write(`ERR_LOG_REG_ADAPTER, 32'h02, 0);
    expect_no_write(10);
  endtask

  task automatic test_edge_and_decode();
    // Level held for 20 cycles with the first request left pending
    sb.opcode_error = 1'b1;
    repeat (20) @(negedge clk);
    sb.opcode_error = 1'b0;
    expect_write(`ERR_LOG_REG_INTERNAL, 32'h04, 0);
    expect_write(`ERR_LOG_REG_UNCORR, 32'h04, 0);
    expect_no_write(30);
    sb.decode = `ERR_LOG_SB_MSG_FATAL;
    sb.valid = 1'b0;
    expect_no_write(10);
    sb.valid = 1'b1;
    @(negedge clk);
    sb.valid = 1'b0;
    expect_write(`ERR_LOG_REG_UNCORR, 32'h08, 0);
    sb.decode = `ERR_LOG_SB_MSG_NONFATAL;
    sb.valid = 1'b1;
    @(negedge clk);
    sb = '0;
    expect_write(`ERR_LOG_REG_UNCORR, 32'h10, 0);
    expect_no_write(10);
  endtask

  task automatic test_priority();
    rx_overflow = 1'b1;
    adp.param_exchange_timeout = 1'b1;
    @(negedge clk);
    rx_overflow = 1'b0;
    adp.param_exchange_timeout = 1'b0;
    expect_write(`ERR_LOG_REG_INTERNAL, 32'h80, 0);
    expect_write(`ERR_LOG_REG_UNCORR, 32'h06, 0);
    expect_write(`ERR_LOG_REG_ADAPTER, 32'h01, 0);
    expect_no_write(10);
  endtask

  task automatic test_backpressure();
    bit seen;
    tx_overflow = 1'b1;
    @(negedge clk);
    tx_overflow = 1'b0;
    wait_for_req(seen);
    // New event lands while the first write is stalled
    @(negedge clk);
    sb.dst_error = 1'b1;
    @(negedge clk);
    sb.dst_error = 1'b0;
    expect_write(`ERR_LOG_REG_INTERNAL, 32'h40, 6);
    expect_write(`ERR_LOG_REG_UNCORR, 32'h04, 3);
    expect_write(`ERR_LOG_REG_INTERNAL, 32'h02, 3);
    expect_no_write(20);
  endtask

  initial begin
    rst = 1'b0;
    phy = '0;
    adp = '0;
    sb = '0;
    tx_overflow = 1'b0;
    rx_overflow = 1'b0;
    csr_ack = 1'b0;
    repeat (10) @(negedge clk);
    rst = 1'b1;
    test_forwarding();
    test_single_events();
    test_edge_and_decode();
    test_priority();
    test_backpressure();
    assert_errs = i_err_log_top.u_writer.u_asserts.fail_cnt;
    $display("Errors: %0d mismatches, %0d other, %0d assertion failures",
             mismatches, other_errs, assert_errs);
    if (mismatches + other_errs + assert_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+src
src/err_log_pkg.sv
src/err_event_detect.sv
src/err_status_log.sv
src/csr_log_writer.sv
src/err_log_top.sv
dv/err_log_asserts.sv
dv/err_log_tb.sv

// ==== src/csr_log_writer.sv ====
`include "err_log_consts.svh"

module csr_log_writer (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  err_log_pkg::internal_err_t i_int_status,
  input  err_log_pkg::uncorr_err_t   i_unc_status,
  input  err_log_pkg::adapter_err_t  i_adp_status,
  input  logic                       i_int_pending,
  input  logic                       i_unc_pending,
  input  logic                       i_adp_pending,
  input  logic                       i_csr_ack,
  output logic                       o_int_take,
  output logic                       o_unc_take,
  output logic                       o_adp_take,
  output logic                       o_csr_req,
  output err_log_pkg::csr_wr_t       o_csr
);

  localparam int DATA_W = `ERR_LOG_CSR_DATA_W;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT_LOW
  } state_e;

  typedef enum logic [1:0] {
    SEL_NONE,
    SEL_INT,
    SEL_UNC,
    SEL_ADP
  } sel_e;

  state_e               state_q;
  state_e               state_d;
  sel_e                 last_q;
  sel_e                 sel;
  logic                 int_ok;
  logic                 unc_ok;
  logic                 adp_ok;
  logic                 take_any;
  err_log_pkg::csr_wr_t csr_d;

  // Fixed priority where the image written last yields to any other
  always_comb begin
    int_ok = i_int_pending &&
             (last_q != SEL_INT || !(i_unc_pending || i_adp_pending));
    unc_ok = i_unc_pending &&
             (last_q != SEL_UNC || !(i_int_pending || i_adp_pending));
    adp_ok = i_adp_pending &&
             (last_q != SEL_ADP || !(i_int_pending || i_unc_pending));
    if (int_ok) begin
      sel = SEL_INT;
    end else if (unc_ok) begin
      sel = SEL_UNC;
    end else if (adp_ok) begin
      sel = SEL_ADP;
    end else begin
      sel = SEL_NONE;
    end
  end

  // Take happens in the idle cycle the image is chosen
  assign o_int_take = (state_q == ST_IDLE) && (sel == SEL_INT);
  assign o_unc_take = (state_q == ST_IDLE) && (sel == SEL_UNC);
  assign o_adp_take = (state_q == ST_IDLE) && (sel == SEL_ADP);
  assign take_any   = o_int_take | o_unc_take | o_adp_take;

  // Address and zero-extended image of the chosen log
  always_comb begin
    csr_d = '0;
    case (sel)
      SEL_INT: begin
        csr_d.addr = `ERR_LOG_REG_INTERNAL;
        csr_d.data = DATA_W'(i_int_status);
      end
      SEL_UNC: begin
        csr_d.addr = `ERR_LOG_REG_UNCORR;
        csr_d.data = DATA_W'(i_unc_status);
      end
      SEL_ADP: begin
        csr_d.addr = `ERR_LOG_REG_ADAPTER;
        csr_d.data = DATA_W'(i_adp_status);
      end
      default: begin
        csr_d = '0;
      end
    endcase
  end

  // Four-phase handshake
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (take_any) begin
          state_d = ST_REQ;
        end
      end
      ST_REQ: begin
        // Drop req as soon as ack is seen
        if (i_csr_ack) begin
          state_d = ST_WAIT_LOW;
        end
      end
      ST_WAIT_LOW: begin
        if (!i_csr_ack) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst) begin
    if (!i_rst) begin
      state_q <= ST_IDLE;
      last_q  <= SEL_NONE;
    end else begin
      state_q <= state_d;
      if (take_any) begin
        last_q <= sel;
      end
    end
  end

  // Write payload held for the whole transfer
  always_ff @(posedge i_clk) begin
    if (take_any) begin
      o_csr <= csr_d;
    end
  end

  assign o_csr_req = (state_q == ST_REQ);

endmodule

// ==== src/err_event_detect.sv ====
`include "err_log_consts.svh"

module err_event_detect (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  err_log_pkg::phy_err_in_t   i_phy,
  input  err_log_pkg::adapter_in_t   i_adp,
  input  err_log_pkg::sb_err_in_t    i_sb,
  input  logic                       i_tx_overflow,
  input  logic                       i_rx_overflow,
  output err_log_pkg::fdi_err_t      o_fdi,
  output err_log_pkg::internal_err_t o_int_evt,
  output err_log_pkg::uncorr_err_t   o_unc_evt,
  output err_log_pkg::adapter_err_t  o_adp_evt
);

  // Every source that ends up in a status image
  typedef struct packed {
    logic sb_src;
    logic sb_dst;
    logic sb_opcode;
    logic sb_unsup;
    logic sb_parity;
    logic sb_fatal;
    logic sb_nonfatal;
    logic tx_ovf;
    logic rx_ovf;
    logic inv_param;
    logic param_tmo;
    logic state_tmo;
    logic adp_tmo;
  } src_t;

  src_t src_now;
  src_t src_q;
  src_t rise;
  logic int_any;

  // FDI forwarding with no added latency
  always_comb begin
    o_fdi.error         = i_phy.error;
    o_fdi.cerror        = i_phy.cerror;
    o_fdi.nferror       = i_phy.nferror;
    o_fdi.trainerror    = i_phy.trainerror | i_adp.invalid_param_exchange;
    o_fdi.phyinrecenter = i_phy.phyinrecenter | i_adp.phyinrecenter;
  end

  // Sideband messages only count while valid
  always_comb begin
    src_now.sb_src      = i_sb.src_error;
    src_now.sb_dst      = i_sb.dst_error;
    src_now.sb_opcode   = i_sb.opcode_error;
    src_now.sb_unsup    = i_sb.unsupported_msg;
    src_now.sb_parity   = i_sb.parity_error;
    src_now.sb_fatal    = i_sb.valid && (i_sb.decode == `ERR_LOG_SB_MSG_FATAL);
    src_now.sb_nonfatal = i_sb.valid && (i_sb.decode == `ERR_LOG_SB_MSG_NONFATAL);
    src_now.tx_ovf      = i_tx_overflow;
    src_now.rx_ovf      = i_rx_overflow;
    src_now.inv_param   = i_adp.invalid_param_exchange;
    src_now.param_tmo   = i_adp.param_exchange_timeout;
    src_now.state_tmo   = i_adp.state_transition_timeout;
    src_now.adp_tmo     = i_adp.adapter_timeout;
  end

  // Previous-cycle copy for edge detection
  always_ff @(posedge i_clk or negedge i_rst) begin
    if (!i_rst) begin
      src_q <= '0;
    end else begin
      src_q <= src_now;
    end
  end

  // Rising edges only, so a held level is logged once
  assign rise = src_t'(src_now & ~src_q);

  always_comb begin
    o_int_evt.rx_overflow     = rise.rx_ovf;
    o_int_evt.tx_overflow     = rise.tx_ovf;
    o_int_evt.reserved        = 1'b0;
    o_int_evt.parity          = rise.sb_parity;
    o_int_evt.unsupported_msg = rise.sb_unsup;
    o_int_evt.opcode          = rise.sb_opcode;
    o_int_evt.dst             = rise.sb_dst;
    o_int_evt.src             = rise.sb_src;
  end

  // Any internal event is also reported as uncorrectable
  assign int_any = rise.sb_src | rise.sb_dst | rise.sb_opcode | rise.sb_unsup |
                   rise.sb_parity | rise.tx_ovf | rise.rx_ovf;

  always_comb begin
    o_unc_evt.invalid_param_exchange = rise.inv_param;
    o_unc_evt.sb_nonfatal_msg        = rise.sb_nonfatal;
    o_unc_evt.sb_fatal_msg           = rise.sb_fatal;
    o_unc_evt.internal_any           = int_any;
    o_unc_evt.rx_overflow            = rise.rx_ovf;
    o_unc_evt.adapter_timeout        = rise.adp_tmo;
  end

  always_comb begin
    o_adp_evt.state_transition_timeout = rise.state_tmo;
    o_adp_evt.param_exchange_timeout   = rise.param_tmo;
  end

endmodule

// ==== src/err_log_consts.svh ====
`ifndef ERR_LOG_CONSTS_SVH
`define ERR_LOG_CONSTS_SVH

// Sideband message decode
`define ERR_LOG_SB_DECODE_W 5

// Error messages received over the sideband
`define ERR_LOG_SB_MSG_NONFATAL 5'h1D
`define ERR_LOG_SB_MSG_FATAL    5'h1E

// CSR write port widths
`define ERR_LOG_CSR_ADDR_W 8
`define ERR_LOG_CSR_DATA_W 32

// Status register addresses in the adapter CSR space
`define ERR_LOG_REG_INTERNAL 8'h24
`define ERR_LOG_REG_ADAPTER  8'h2C
`define ERR_LOG_REG_UNCORR   8'h34

`endif

// ==== src/err_log_pkg.sv ====
`include "err_log_consts.svh"

package err_log_pkg;

  // Indications from the physical layer (RDI)
  typedef struct packed {
    logic error;
    logic cerror;
    logic nferror;
    logic trainerror;
    logic phyinrecenter;
  } phy_err_in_t;

  // Conditions raised inside the adapter
  typedef struct packed {
    logic phyinrecenter;
    logic invalid_param_exchange;
    logic param_exchange_timeout;
    logic state_transition_timeout;
    logic adapter_timeout;
  } adapter_in_t;

  // Sideband receive status
  typedef struct packed {
    logic                                valid;
    logic [`ERR_LOG_SB_DECODE_W-1:0]     decode;
    logic                                src_error;
    logic                                dst_error;
    logic                                opcode_error;
    logic                                unsupported_msg;
    logic                                parity_error;
  } sb_err_in_t;

  // Toward the protocol layer (FDI)
  typedef struct packed {
    logic error;
    logic cerror;
    logic nferror;
    logic trainerror;
    logic phyinrecenter;
  } fdi_err_t;

  // Internal error status register image
  typedef struct packed {
    logic rx_overflow;
    logic tx_overflow;
    logic reserved;
    logic parity;
    logic unsupported_msg;
    logic opcode;
    logic dst;
    logic src;
  } internal_err_t;

  // Uncorrectable error status register image
  typedef struct packed {
    logic invalid_param_exchange;
    logic sb_nonfatal_msg;
    logic sb_fatal_msg;
    logic internal_any;
    logic rx_overflow;
    logic adapter_timeout;
  } uncorr_err_t;

  // Adapter error status register image
  typedef struct packed {
    logic state_transition_timeout;
    logic param_exchange_timeout;
  } adapter_err_t;

  // One write on the CSR port
  typedef struct packed {
    logic [`ERR_LOG_CSR_ADDR_W-1:0] addr;
    logic [`ERR_LOG_CSR_DATA_W-1:0] data;
  } csr_wr_t;

endpackage

// ==== src/err_log_top.sv ====
module err_log_top (
  input  logic                     i_clk,
  input  logic                     i_rst,
  input  err_log_pkg::phy_err_in_t i_phy,
  input  err_log_pkg::adapter_in_t i_adp,
  input  err_log_pkg::sb_err_in_t  i_sb,
  input  logic                     i_tx_overflow,
  input  logic                     i_rx_overflow,
  input  logic                     i_csr_ack,
  output err_log_pkg::fdi_err_t    o_fdi,
  output logic                     o_csr_req,
  output err_log_pkg::csr_wr_t     o_csr
);

  // Per-cycle events
  err_log_pkg::internal_err_t int_evt;
  err_log_pkg::uncorr_err_t   unc_evt;
  err_log_pkg::adapter_err_t  adp_evt;

  // Sticky images and their write hooks
  err_log_pkg::internal_err_t int_status;
  err_log_pkg::uncorr_err_t   unc_status;
  err_log_pkg::adapter_err_t  adp_status;
  logic                       int_pending;
  logic                       unc_pending;
  logic                       adp_pending;
  logic                       int_take;
  logic                       unc_take;
  logic                       adp_take;

  err_event_detect u_detect (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_phy        (i_phy),
    .i_adp        (i_adp),
    .i_sb         (i_sb),
    .i_tx_overflow(i_tx_overflow),
    .i_rx_overflow(i_rx_overflow),
    .o_fdi        (o_fdi),
    .o_int_evt    (int_evt),
    .o_unc_evt    (unc_evt),
    .o_adp_evt    (adp_evt)
  );

  err_status_log #(.T_STATUS(err_log_pkg::internal_err_t)) u_int_log (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_evt    (int_evt),
    .i_take   (int_take),
    .o_status (int_status),
    .o_pending(int_pending)
  );

  err_status_log #(.T_STATUS(err_log_pkg::uncorr_err_t)) u_unc_log (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_evt    (unc_evt),
    .i_take   (unc_take),
    .o_status (unc_status),
    .o_pending(unc_pending)
  );

  err_status_log #(.T_STATUS(err_log_pkg::adapter_err_t)) u_adp_log (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_evt    (adp_evt),
    .i_take   (adp_take),
    .o_status (adp_status),
    .o_pending(adp_pending)
  );

  csr_log_writer u_writer (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_int_status (int_status),
    .i_unc_status (unc_status),
    .i_adp_status (adp_status),
    .i_int_pending(int_pending),
    .i_unc_pending(unc_pending),
    .i_adp_pending(adp_pending),
    .i_csr_ack    (i_csr_ack),
    .o_int_take   (int_take),
    .o_unc_take   (unc_take),
    .o_adp_take   (adp_take),
    .o_csr_req    (o_csr_req),
    .o_csr        (o_csr)
  );

endmodule

// ==== src/err_status_log.sv ====
module err_status_log #(
  parameter type T_STATUS = logic
) (
  input  logic    i_clk,
  input  logic    i_rst,
  input  T_STATUS i_evt,
  input  logic    i_take,
  output T_STATUS o_status,
  output logic    o_pending
);

  T_STATUS status_q;
  T_STATUS status_d;

  // Sticky bits; on take only the events of this cycle survive
  always_comb begin
    if (i_take) begin
      status_d = i_evt;
    end else begin
      status_d = T_STATUS'(status_q | i_evt);
    end
  end

  always_ff @(posedge i_clk or negedge i_rst) begin
    if (!i_rst) begin
      status_q <= '0;
    end else begin
      status_q <= status_d;
    end
  end

  assign o_status = status_q;

  // Something is waiting to be written
  assign o_pending = (status_q != '0);

endmodule
